//--- flist.f
design/lsab_pkg.sv
design/slot_feeder.sv
design/chan_fifo.sv
design/fill_engine.sv
design/lsab_fill_top.sv
tests/wb_mem_model.sv
tests/tb_lsab_fill.sv

//--- Makefile
# Verilator build and run of the fill path testbench

VERILATOR ?= verilator
TOP       ?= tb_lsab_fill
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_lsab_fill.sv
// Directed testbench for the fill path, checking memory writes and block reports
`default_nettype none
`timescale 1ns/1ps

module tb_lsab_fill;

  localparam int SLOT_WAIT  = 16;    // Cycles to reach a wanted slot
  localparam int DRAIN_WAIT = 4000;  // Cycles to empty all buffers

  logic                              CLK_n;
  logic                              RST;
  logic                              i_write;
  logic [lsab_pkg::DATA_W-1:0]       i_data;
  logic [lsab_pkg::ANC_W-1:0]        i_anc;
  logic                              i_int;
  logic [lsab_pkg::CHAN_W-1:0]       o_write_slot;
  logic [lsab_pkg::NUM_CHAN-1:0]     o_chan_full;
  logic                              o_wb_cyc;
  logic                              o_wb_stb;
  logic                              o_wb_we;
  logic [lsab_pkg::ADDR_W-1:0]       o_wb_adr;
  logic [lsab_pkg::DATA_W-1:0]       o_wb_dat;
  logic                              i_wb_ack;
  logic                              o_blk_done;
  logic [lsab_pkg::CHAN_W-1:0]       o_blk_chan;
  logic [lsab_pkg::COUNT_W-1:0]      o_blk_count;
  logic                              o_blk_irq;
  logic [lsab_pkg::ANC_W-1:0]        o_blk_anc;
  logic                              mem_stall;
  logic [3:0]                        mem_delay;

  // Reference state
  lsab_pkg::lsab_word_t              exp_q [lsab_pkg::NUM_CHAN][$];
  logic [lsab_pkg::REGION_W-1:0]     exp_off [lsab_pkg::NUM_CHAN];
  int                                sent_total [lsab_pkg::NUM_CHAN];
  logic [lsab_pkg::CHAN_W-1:0]       rep_chan [$];
  logic [lsab_pkg::COUNT_W-1:0]      rep_count [$];
  logic [lsab_pkg::DATA_W-1:0]       exp_img [2**lsab_pkg::ADDR_W];
  bit                                img_valid [2**lsab_pkg::ADDR_W];
  int                                blk_words;
  logic [lsab_pkg::CHAN_W-1:0]       blk_chan;
  logic [lsab_pkg::DATA_W-1:0]       last_data;
  lsab_pkg::lsab_word_t              last_word;
  bit                                must_end;  // Report due after the closing word

  lsab_fill_top u_lsab_fill_top (
    .CLK_n (CLK_n), .RST (RST),
    .i_write (i_write), .i_data (i_data), .i_anc (i_anc), .i_int (i_int),
    .o_write_slot (o_write_slot), .o_chan_full (o_chan_full),
    .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .o_wb_we (o_wb_we),
    .o_wb_adr (o_wb_adr), .o_wb_dat (o_wb_dat), .i_wb_ack (i_wb_ack),
    .o_blk_done (o_blk_done), .o_blk_chan (o_blk_chan), .o_blk_count (o_blk_count),
    .o_blk_irq (o_blk_irq), .o_blk_anc (o_blk_anc)
  );

  wb_mem_model u_mem (
    .CLK_n (CLK_n), .RST (RST),
    .i_cyc (o_wb_cyc), .i_stb (o_wb_stb), .i_we (o_wb_we),
    .i_adr (o_wb_adr), .i_dat (o_wb_dat),
    .i_stall (mem_stall), .i_delay (mem_delay), .o_ack (i_wb_ack)
  );

  always #10 CLK_n = ~CLK_n;

  // --------------------------------------------------
  // Error reporting and compare tasks
  // --------------------------------------------------
  task automatic show_mismatch(input string name, input logic [63:0] got, exp);
    $display("FAILED %s: got %h, expected %h", name, got, exp);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input lsab_pkg::lsab_word_t got, exp);
    if (got !== exp) show_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_data(input string name, input logic [lsab_pkg::DATA_W-1:0] got, exp);
    if (got !== exp) show_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_addr(input string name, input logic [lsab_pkg::ADDR_W-1:0] got, exp);
    if (got !== exp) show_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_chan(input string name, input logic [lsab_pkg::CHAN_W-1:0] got, exp);
    if (got !== exp) show_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_count(input string name, input logic [lsab_pkg::COUNT_W-1:0] got, exp);
    if (got !== exp) show_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) show_mismatch(name, 64'(got), 64'(exp));
  endtask

  // Memory contents against the image of every write seen on the bus
  task automatic check_memory();
    for (int a = 0; a < 2**lsab_pkg::ADDR_W; a++)
      if (img_valid[a])
        check_data("u_mem.mem", u_mem.mem[a], exp_img[a]);
  endtask

  // --------------------------------------------------
  // Bus and report monitor
  // --------------------------------------------------
  always @(negedge CLK_n)
  begin : bus_monitor
    logic [lsab_pkg::CHAN_W-1:0] ch;
    lsab_pkg::lsab_word_t        exp_w;
    if (RST && must_end && !o_blk_done)
      stop_run("no block report in the cycle after the block's closing word");
    if (RST && o_wb_stb)
    begin
      check_flag("o_wb_we", o_wb_we, 1'b1);
      check_flag("o_wb_cyc", o_wb_cyc, 1'b1);
    end
    if (RST && o_wb_stb && i_wb_ack)
    begin
      ch = o_wb_adr[lsab_pkg::ADDR_W-1 -: lsab_pkg::CHAN_W];
      if (exp_q[ch].size() == 0)
        stop_run("memory write for a channel with no word outstanding");
      exp_w = exp_q[ch].pop_front();
      check_addr("o_wb_adr", o_wb_adr, {ch, exp_off[ch]});
      check_data("o_wb_dat", o_wb_dat, exp_w.data);
      exp_img[{ch, exp_off[ch]}]   = exp_w.data;
      img_valid[{ch, exp_off[ch]}] = 1'b1;
      if (blk_words == 0)
        blk_chan = ch;
      else
        check_chan("o_wb_adr channel", ch, blk_chan);  // One channel per block
      exp_off[ch] = exp_off[ch] + 1'b1;  // Region wraps at 64
      blk_words++;
      last_word = exp_w;
      last_data = o_wb_dat;
      must_end  = (blk_words == lsab_pkg::BLOCK_WORDS) || exp_w.intr;
    end
    if (RST && o_blk_done)
    begin
      if (blk_words == 0)
        stop_run("block report without any memory write");
      if (o_blk_count > lsab_pkg::COUNT_W'(lsab_pkg::BLOCK_WORDS))
        stop_run("block report count above the block limit");
      check_chan("o_blk_chan", o_blk_chan, blk_chan);
      check_count("o_blk_count", o_blk_count, lsab_pkg::COUNT_W'(blk_words));
      check_word("o_blk_irq/o_blk_anc", {o_blk_irq, o_blk_anc, last_data}, last_word);
      rep_chan.push_back(o_blk_chan);
      rep_count.push_back(o_blk_count);
      blk_words = 0;
      must_end  = 1'b0;
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic lsab_pkg::lsab_word_t make_word(input logic intr);
    lsab_pkg::lsab_word_t w;
    w.intr = intr;
    w.anc  = lsab_pkg::ANC_W'($urandom);
    w.data = $urandom;
    return w;
  endfunction

  // Waits for the channel's slot, then offers one word for a cycle
  task automatic send_word(input logic [lsab_pkg::CHAN_W-1:0] ch,
                           input lsab_pkg::lsab_word_t w, input bit taken);
    int n;
    n = 0;
    @(negedge CLK_n);
    while (o_write_slot != ch)
    begin
      n++;
      if (n > SLOT_WAIT) stop_run("write slot never reached the wanted channel");
      @(negedge CLK_n);
    end
    i_write = 1'b1;
    i_data  = w.data;
    i_anc   = w.anc;
    i_int   = w.intr;
    if (taken)
    begin
      exp_q[ch].push_back(w);
      sent_total[ch]++;
    end
    @(negedge CLK_n);
    i_write = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    bit busy;
    n    = 0;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge CLK_n);
      busy = o_wb_cyc;
      for (int c = 0; c < lsab_pkg::NUM_CHAN; c++)
        if (exp_q[c].size() != 0) busy = 1'b1;
      n++;
      if (busy && n > DRAIN_WAIT) stop_run("memory writes did not finish in time");
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_state_test();
    logic [lsab_pkg::CHAN_W-1:0] slot;
    slot = '0;
    for (int i = 0; i < 8; i++)
    begin
      check_chan("o_write_slot", o_write_slot, slot);
      check_flag("o_wb_cyc", o_wb_cyc, 1'b0);
      check_flag("o_wb_stb", o_wb_stb, 1'b0);
      check_flag("o_blk_done", o_blk_done, 1'b0);
      slot = slot + 1'b1;
      @(negedge CLK_n);
    end
  endtask

  task automatic single_message_test();
    int base;
    base      = rep_count.size();
    mem_stall = 1'b1;  // Whole message buffered before the first ack
    for (int i = 0; i < 3; i++)
      send_word(2'd1, make_word(i == 2), 1'b1);
    mem_stall = 1'b0;
    wait_drained();
    if (rep_count.size() != base + 1) stop_run("expected one block report for the message");
    check_chan("o_blk_chan", rep_chan[base], 2'd1);
    check_count("o_blk_count", rep_count[base], 4'd3);
  endtask

  task automatic block_cap_test();
    int base;
    base      = rep_count.size();
    mem_stall = 1'b1;
    for (int i = 0; i < 12; i++)
      send_word(2'd0, make_word(1'b0), 1'b1);
    mem_stall = 1'b0;
    wait_drained();
    if (rep_count.size() != base + 2) stop_run("expected two block reports for 12 words");
    check_chan("o_blk_chan", rep_chan[base], 2'd0);
    check_count("o_blk_count", rep_count[base], 4'd8);
    check_count("o_blk_count", rep_count[base + 1], 4'd4);
    check_chan("o_blk_chan", rep_chan[base + 1], 2'd0);
  endtask

  task automatic full_backpressure_test();
    mem_stall = 1'b1;
    for (int i = 0; i < 20; i++)
    begin
      check_flag("o_chan_full[2]", o_chan_full[2], i >= lsab_pkg::FIFO_DEPTH);
      send_word(2'd2, make_word(1'b0), i < lsab_pkg::FIFO_DEPTH);  // Last 4 dropped
    end
    mem_stall = 1'b0;
    wait_drained();
    check_flag("o_chan_full[2]", o_chan_full[2], 1'b0);
  endtask

  task automatic mixed_traffic_test();
    int base;
    int sum;
    logic [lsab_pkg::CHAN_W-1:0] ch;
    base = rep_count.size();
    sum  = 0;
    for (int i = 0; i < 80; i++)
    begin
      // Channel 2 favoured so its region offset wraps
      ch = ($urandom_range(0, 7) < 5) ? 2'd2 : lsab_pkg::CHAN_W'($urandom_range(0, 3));
      mem_delay = 4'($urandom_range(0, 2));
      check_flag("o_chan_full", o_chan_full[ch], 1'b0);
      send_word(ch, make_word($urandom_range(0, 5) == 0), 1'b1);
      repeat ($urandom_range(2, 6)) @(negedge CLK_n);
    end
    wait_drained();
    for (int r = base; r < rep_count.size(); r++)
      sum += int'(rep_count[r]);
    if (sum != 80) show_mismatch("block count sum", 64'(sum), 64'(80));
    if (sent_total[2] <= 64) stop_run("channel 2 region offset never wrapped");
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    CLK_n     = 1'b0;
    RST       = 1'b0;
    i_write   = 1'b0;
    i_data    = '0;
    i_anc     = '0;
    i_int     = 1'b0;
    mem_stall = 1'b0;
    mem_delay = '0;
    blk_words = 0;
    blk_chan  = '0;
    last_data = '0;
    last_word = '0;
    must_end  = 1'b0;
    for (int c = 0; c < lsab_pkg::NUM_CHAN; c++)
    begin
      exp_off[c]    = '0;
      sent_total[c] = 0;
    end
    void'($urandom(32'hbe89aa8b));

    repeat (3) @(posedge CLK_n);
    @(negedge CLK_n);
    RST = 1'b1;

    reset_state_test();
    single_message_test();
    block_cap_test();
    full_backpressure_test();
    mixed_traffic_test();
    check_memory();

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/wb_mem_model.sv
// Wishbone classic slave memory for the testbench, with a settable ack delay and an ack stall
`default_nettype none
`timescale 1ns/1ps

module wb_mem_model (
  input  wire                          CLK_n,
  input  wire                          RST,
  input  wire                          i_cyc,
  input  wire                          i_stb,
  input  wire                          i_we,
  input  wire [lsab_pkg::ADDR_W-1:0]   i_adr,
  input  wire [lsab_pkg::DATA_W-1:0]   i_dat,
  input  wire                          i_stall,  // Holds every ack back
  input  wire [3:0]                    i_delay,  // Wait cycles before ack
  output logic                         o_ack
);

  logic [lsab_pkg::DATA_W-1:0] mem [2**lsab_pkg::ADDR_W];
  logic [3:0]                  wait_cnt;

  always_ff @(posedge CLK_n)
  begin
    if (i_cyc && i_stb && i_we && o_ack)
    begin
      mem[i_adr] <= i_dat;
    end
  end

  // One ack pulse per request
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_ack    <= 1'b0;
      wait_cnt <= '0;
    end
    else if (o_ack)
    begin
      o_ack    <= 1'b0;
      wait_cnt <= '0;
    end
    else if (i_cyc && i_stb && !i_stall)
    begin
      if (wait_cnt >= i_delay)
      begin
        o_ack <= 1'b1;
      end
      else
      begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/lsab_fill_top.sv
// Top level of the input path: slot feeder, four channel buffers and the Wishbone fill engine
`default_nettype none
`timescale 1ns/1ps

module lsab_fill_top (
  input  wire                              CLK_n,
  input  wire                              RST,
  // ------------------------------------------------
  // Source side
  // ------------------------------------------------
  input  wire                              i_write,
  input  wire [lsab_pkg::DATA_W-1:0]       i_data,
  input  wire [lsab_pkg::ANC_W-1:0]        i_anc,
  input  wire                              i_int,
  output logic [lsab_pkg::CHAN_W-1:0]      o_write_slot,
  output logic [lsab_pkg::NUM_CHAN-1:0]    o_chan_full,
  // ------------------------------------------------
  // Wishbone master to memory
  // ------------------------------------------------
  output logic                             o_wb_cyc,
  output logic                             o_wb_stb,
  output logic                             o_wb_we,
  output logic [lsab_pkg::ADDR_W-1:0]      o_wb_adr,
  output logic [lsab_pkg::DATA_W-1:0]      o_wb_dat,
  input  wire                              i_wb_ack,
  // ------------------------------------------------
  // Block report
  // ------------------------------------------------
  output logic                             o_blk_done,
  output logic [lsab_pkg::CHAN_W-1:0]      o_blk_chan,
  output logic [lsab_pkg::COUNT_W-1:0]     o_blk_count,
  output logic                             o_blk_irq,
  output logic [lsab_pkg::ANC_W-1:0]       o_blk_anc
);

  logic [lsab_pkg::NUM_CHAN-1:0] push;
  logic [lsab_pkg::NUM_CHAN-1:0] pop;
  logic [lsab_pkg::NUM_CHAN-1:0] empty;
  lsab_pkg::lsab_word_t          word;   // Broadcast to all buffers
  lsab_pkg::lsab_word_t          head [lsab_pkg::NUM_CHAN];

  slot_feeder u_feeder (
    .CLK_n   (CLK_n),
    .RST     (RST),
    .i_write (i_write),
    .i_data  (i_data),
    .i_anc   (i_anc),
    .i_int   (i_int),
    .i_full  (o_chan_full),
    .o_slot  (o_write_slot),
    .o_push  (push),
    .o_word  (word)
  );

  // One buffer per channel
  for (genvar c = 0; c < lsab_pkg::NUM_CHAN; c++)
  begin : g_chan
    chan_fifo u_fifo (
      .CLK_n   (CLK_n),
      .RST     (RST),
      .i_push  (push[c]),
      .i_word  (word),
      .i_pop   (pop[c]),
      .o_head  (head[c]),
      .o_empty (empty[c]),
      .o_full  (o_chan_full[c])
    );
  end

  fill_engine u_engine (
    .CLK_n       (CLK_n),
    .RST         (RST),
    .i_empty     (empty),
    .i_head      (head),
    .o_pop       (pop),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_dat    (o_wb_dat),
    .i_wb_ack    (i_wb_ack),
    .o_blk_done  (o_blk_done),
    .o_blk_chan  (o_blk_chan),
    .o_blk_count (o_blk_count),
    .o_blk_irq   (o_blk_irq),
    .o_blk_anc   (o_blk_anc)
  );

endmodule

`default_nettype wire

//--- design/fill_engine.sv
// Round-robin block mover draining the channel buffers into per-channel memory regions
`default_nettype none
`timescale 1ns/1ps

module fill_engine (
  input  wire                              CLK_n,
  input  wire                              RST,
  // Channel buffers
  input  wire [lsab_pkg::NUM_CHAN-1:0]     i_empty,
  input  wire lsab_pkg::lsab_word_t        i_head [lsab_pkg::NUM_CHAN],
  output logic [lsab_pkg::NUM_CHAN-1:0]    o_pop,
  // Wishbone classic master, writes only
  output logic                             o_wb_cyc,
  output logic                             o_wb_stb,
  output logic                             o_wb_we,
  output logic [lsab_pkg::ADDR_W-1:0]      o_wb_adr,
  output logic [lsab_pkg::DATA_W-1:0]      o_wb_dat,
  input  wire                              i_wb_ack,
  // Block report
  output logic                             o_blk_done,
  output logic [lsab_pkg::CHAN_W-1:0]      o_blk_chan,
  output logic [lsab_pkg::COUNT_W-1:0]     o_blk_count,
  output logic                             o_blk_irq,
  output logic [lsab_pkg::ANC_W-1:0]       o_blk_anc
);

  // S_REPORT is the cycle after every ack and either closes the block or resumes
  typedef enum logic [1:0] {S_IDLE, S_WRITE, S_REPORT} state_t;

  state_t                            state;
  logic [lsab_pkg::CHAN_W-1:0]       rr_ptr;    // First channel looked at
  logic [lsab_pkg::CHAN_W-1:0]       cur_chan;
  logic [lsab_pkg::REGION_W-1:0]     offset [lsab_pkg::NUM_CHAN];
  logic [lsab_pkg::COUNT_W-1:0]      blk_count;
  logic                              last_hit;  // Cap or irq word seen at last ack
  logic                              last_irq;
  logic [lsab_pkg::ANC_W-1:0]        last_anc;

  logic [lsab_pkg::CHAN_W-1:0]       pick_chan;
  logic                              pick_valid;
  logic                              ack_hit;
  logic                              cap_hit;
  logic                              blk_end;
  lsab_pkg::lsab_word_t              cur_head;

  // ------------------------------------------------
  // Round-robin pick
  // ------------------------------------------------
  always_comb
  begin
    logic [lsab_pkg::CHAN_W-1:0] idx;
    pick_chan  = rr_ptr;
    pick_valid = 1'b0;
    for (int i = 0; i < lsab_pkg::NUM_CHAN; i++)
    begin
      idx = rr_ptr + lsab_pkg::CHAN_W'(i);  // Wraps past the last channel
      if (!pick_valid && !i_empty[idx])
      begin
        pick_chan  = idx;
        pick_valid = 1'b1;
      end
    end
  end

  assign cur_head = i_head[cur_chan];
  assign ack_hit  = o_wb_stb && i_wb_ack;
  assign cap_hit  = (blk_count == lsab_pkg::COUNT_W'(lsab_pkg::BLOCK_WORDS - 1));

  // Empty flag already reflects the pop in S_REPORT
  assign blk_end  = (state == S_REPORT) && (last_hit || i_empty[cur_chan]);

  // ------------------------------------------------
  // Bus and buffer outputs
  // ------------------------------------------------
  assign o_wb_we  = o_wb_stb;
  assign o_wb_adr = {cur_chan, offset[cur_chan]};
  assign o_wb_dat = cur_head.data;

  always_comb
  begin
    o_pop = '0;
    if (ack_hit)
    begin
      o_pop[cur_chan] = 1'b1;  // Head leaves at the ack edge
    end
  end

  assign o_blk_done  = blk_end;
  assign o_blk_chan  = cur_chan;
  assign o_blk_count = blk_count;
  assign o_blk_irq   = last_irq;
  assign o_blk_anc   = last_anc;

  // ------------------------------------------------
  // Control FSM
  // ------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      state     <= S_IDLE;
      o_wb_cyc  <= 1'b0;
      o_wb_stb  <= 1'b0;
      rr_ptr    <= '0;
      cur_chan  <= '0;
      blk_count <= '0;
      last_hit  <= 1'b0;
      for (int c = 0; c < lsab_pkg::NUM_CHAN; c++)
      begin
        offset[c] <= '0;
      end
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (pick_valid)
          begin
            cur_chan  <= pick_chan;
            blk_count <= '0;
            last_hit  <= 1'b0;
            o_wb_cyc  <= 1'b1;  // cyc and stb rise together
            o_wb_stb  <= 1'b1;
            state     <= S_WRITE;
          end
        end
        S_WRITE:
        begin
          if (i_wb_ack)  // Late ack just stretches this state
          begin
            o_wb_stb         <= 1'b0;
            blk_count        <= blk_count + 1'b1;
            offset[cur_chan] <= offset[cur_chan] + 1'b1;  // Wraps at 64
            last_hit         <= cap_hit || cur_head.intr;
            state            <= S_REPORT;
          end
        end
        S_REPORT:
        begin
          if (blk_end)
          begin
            o_wb_cyc <= 1'b0;
            rr_ptr   <= cur_chan + 1'b1;
            state    <= S_IDLE;
          end
          else
          begin
            o_wb_stb <= 1'b1;
            state    <= S_WRITE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Tags of the word just written go out if it closes the block
  always_ff @(posedge CLK_n)
  begin
    if (ack_hit)
    begin
      last_irq <= cur_head.intr;
      last_anc <= cur_head.anc;
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // Classic cycle holds the request until acknowledged
  a_wb_hold: assert property (
    @(posedge CLK_n) disable iff (!RST)
    (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_dat))
  );

  a_blk_size: assert property (
    @(posedge CLK_n) disable iff (!RST)
    o_blk_done |-> (o_blk_count != '0 &&
                    o_blk_count <= lsab_pkg::COUNT_W'(lsab_pkg::BLOCK_WORDS))
  );

endmodule

`default_nettype wire

//--- design/chan_fifo.sv
// First-word-fall-through buffer for one source channel, drained by the fill engine
`default_nettype none
`timescale 1ns/1ps

module chan_fifo (
  input  wire                   CLK_n,
  input  wire                   RST,
  input  wire                   i_push,
  input  wire lsab_pkg::lsab_word_t i_word,
  input  wire                   i_pop,
  output lsab_pkg::lsab_word_t  o_head,
  output logic                  o_empty,
  output logic                  o_full
);

  lsab_pkg::lsab_word_t mem [lsab_pkg::FIFO_DEPTH];

  logic [lsab_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [lsab_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [lsab_pkg::FIFO_CNT_W-1:0] count;

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (i_push)
    begin
      mem[wr_ptr] <= i_word;
    end
  end

  assign o_head = mem[rd_ptr];  // Valid whenever not empty

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      end
      if (i_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  // Flags come from the registered count, so they move one cycle after the edge
  assign o_empty = (count == '0);
  assign o_full  = (count == lsab_pkg::FIFO_CNT_W'(lsab_pkg::FIFO_DEPTH));

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // The feeder must honour o_full
  a_no_push_full: assert property (
    @(posedge CLK_n) disable iff (!RST)
    o_full |-> !i_push
  );

  // The fill engine must only pop a channel it saw as non-empty
  a_no_pop_empty: assert property (
    @(posedge CLK_n) disable iff (!RST)
    o_empty |-> !i_pop
  );

endmodule

`default_nettype wire

//--- design/slot_feeder.sv
// Rotating write slot for the sources; steers each accepted word to the buffer that owns the slot
`default_nettype none
`timescale 1ns/1ps

module slot_feeder (
  input  wire                              CLK_n,
  input  wire                              RST,
  // Source side
  input  wire                              i_write,
  input  wire [lsab_pkg::DATA_W-1:0]       i_data,
  input  wire [lsab_pkg::ANC_W-1:0]        i_anc,
  input  wire                              i_int,
  // Buffer side
  input  wire [lsab_pkg::NUM_CHAN-1:0]     i_full,
  output logic [lsab_pkg::CHAN_W-1:0]      o_slot,
  output logic [lsab_pkg::NUM_CHAN-1:0]    o_push,
  output lsab_pkg::lsab_word_t             o_word
);

  // ------------------------------------------------
  // Slot counter
  // ------------------------------------------------
  // NUM_CHAN is a power of two, so the counter wraps on its own
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_slot <= '0;
    end
    else
    begin
      o_slot <= o_slot + 1'b1;
    end
  end

  // ------------------------------------------------
  // Steering
  // ------------------------------------------------
  // Word dropped when the slot owner is full
  always_comb
  begin
    o_push = '0;
    if (i_write && !i_full[o_slot])
    begin
      o_push[o_slot] = 1'b1;
    end
  end

  // Same word goes to every buffer and only one push bit qualifies it
  always_comb
  begin
    o_word.intr = i_int;
    o_word.anc  = i_anc;
    o_word.data = i_data;
  end

endmodule

`default_nettype wire

//--- design/lsab_pkg.sv
// Shared widths, counts and the buffered word type for the channel-to-memory fill path
`default_nettype none

package lsab_pkg;

  // ------------------------------------------------
  // Source side
  // ------------------------------------------------
  localparam int NUM_CHAN = 4;   // Card-reader channels
  localparam int CHAN_W   = 2;   // Channel index
  localparam int DATA_W   = 32;
  localparam int ANC_W    = 25;  // Ancillary tag carried with each word

  // ------------------------------------------------
  // Channel buffers
  // ------------------------------------------------
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // Holds 0 to FIFO_DEPTH

  // ------------------------------------------------
  // Fill engine and memory map
  // ------------------------------------------------
  localparam int BLOCK_WORDS = 8;  // Max words per block
  localparam int COUNT_W     = 4;
  localparam int REGION_W    = 6;  // 64 words per channel region

  // Word address is {channel, region offset}
  localparam int ADDR_W = CHAN_W + REGION_W;

  // One buffered word of 58 bits
  typedef struct packed {
    logic              intr;  // Closes a message
    logic [ANC_W-1:0]  anc;
    logic [DATA_W-1:0] data;
  } lsab_word_t;

endpackage

`default_nettype wire
